/* list.f */
+incdir+verification
rtl/sync_cmd_pkg.sv
rtl/sync_timing_pkg.sv
rtl/orbit_timer.sv
rtl/sync_sequencer.sv
rtl/command_serializer.sv
rtl/sync_tx_top.sv
verification/tb_sync_tx.sv

/* rtl/command_serializer.sv */
////////////////////////////////////////////////////////////////////////////
// Fast command serializer
// Encodes a 4-bit command into an (8,4) Hamming frame and shifts it out
// MSB first on the resync line, one bit per clock
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module command_serializer (
   input  logic               clk,
   input  logic               RST_A,
   input  sync_cmd_pkg::cmd_t cmd,
   input  logic               cmd_load,
   output logic               resync,
   output logic               frame_strobe,
   output logic               frame_done
);

   import sync_cmd_pkg::*;
   import sync_timing_pkg::*;

   // Parity bits in 0, 1 and 3, data in 2 and 6..4
   function automatic frame_t encode(input cmd_t c);
      frame_t f;
      f[0]   = c[0] ^ c[1] ^ c[3];
      f[1]   = c[0] ^ c[2] ^ c[3];
      f[2]   = c[0];
      f[3]   = c[1] ^ c[2] ^ c[3];
      f[6:4] = c[3:1];
      f[7]   = 1'b0;
      return f;
   endfunction

   frame_t   shift_q;
   bit_cnt_t bit_cnt_q;
   logic     active_q;
   logic     last_bit;

   assign last_bit = (bit_cnt_q == bit_cnt_t'(frame_bits - 1));

   always_ff @(posedge clk) begin
      if (!RST_A) begin
         shift_q   <= '0;
         bit_cnt_q <= '0;
         active_q  <= 1'b0;
      end else if (cmd_load) begin
         // A load on the last bit keeps frames back to back
         shift_q   <= encode(cmd);
         bit_cnt_q <= '0;
         active_q  <= 1'b1;
      end else begin
         shift_q <= {shift_q[frame_bits-2:0], 1'b0};
         if (active_q) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (last_bit) begin
               active_q <= 1'b0;
            end
         end
      end
   end

   assign resync       = shift_q[frame_bits-1];
   assign frame_strobe = active_q && (bit_cnt_q == '0);
   assign frame_done   = active_q && last_bit;

endmodule

/* rtl/orbit_timer.sv */
////////////////////////////////////////////////////////////////////////////
// Orbit timer
// Free-running period counter that pulses once per orbit while enabled
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module orbit_timer #(
   parameter int orbit_period = 3564
) (
   input  logic clk,
   input  logic RST_A,
   input  logic orbit_enable,
   output logic orbit_tick
);

   import sync_timing_pkg::*;

   // Last count before the wrap
   localparam orbit_cnt_t cnt_last = orbit_cnt_t'(orbit_period - 1);

   orbit_cnt_t cnt_q;
   logic       tick_q;
   logic       wrap;

   assign wrap = (cnt_q == cnt_last);

   always_ff @(posedge clk) begin
      if (!RST_A) begin
         cnt_q  <= '0;
         tick_q <= 1'b0;
      end else if (!orbit_enable) begin
         // Held at zero so the next enable restarts a full period
         cnt_q  <= '0;
         tick_q <= 1'b0;
      end else begin
         tick_q <= wrap;
         if (wrap) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   assign orbit_tick = tick_q;

endmodule

/* rtl/sync_cmd_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Fast command definitions for the resync transmitter
// Command codes carried on the serial line and the encoded frame format
////////////////////////////////////////////////////////////////////////////

package sync_cmd_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Frame format
   ////////////////////////////////////////////////////////////////////////////

   // Bits per encoded frame, sent MSB first
   localparam int frame_bits = 8;

   // Raw 4-bit fast command
   typedef logic [3:0] cmd_t;

   // Hamming-protected frame, top bit always zero
   typedef logic [frame_bits-1:0] frame_t;

   ////////////////////////////////////////////////////////////////////////////
   // Command codes
   ////////////////////////////////////////////////////////////////////////////

   // Closes a command sequence
   localparam cmd_t cmd_stop        = 4'd0;

   // Opens a command sequence
   localparam cmd_t cmd_start       = 4'd1;

   // Start-up sequence payload
   localparam cmd_t cmd_dtu_reset   = 4'd2;
   localparam cmd_t cmd_normal_mode = 4'd6;

   // Bunch crossing zero marker, sent once per orbit
   localparam cmd_t cmd_bc0         = 4'd14;

endpackage

/* rtl/sync_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// Resync command sequencer
// Chooses the start-up or orbit sequence and feeds its four commands to
// the serializer, one per frame, keeping a late orbit request pending
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module sync_sequencer (
   input  logic                clk,
   input  logic                RST_A,
   input  logic                init_req,
   input  logic                orbit_tick,
   input  logic                frame_done,
   output sync_cmd_pkg::cmd_t  cmd,
   output logic                cmd_load,
   output logic                busy
);

   import sync_cmd_pkg::*;
   import sync_timing_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_startup,
      st_orbit
   } state_t;

   state_t state_q;
   slot_t  slot_q;
   logic   pending_q;
   logic   load_q;

   logic   last_slot;
   logic   next_load;
   logic   chain_orbit;
   logic   use_orbit;
   slot_t  cmd_slot;

   ////////////////////////////////////////////////////////////////////////////
   // Load decisions
   ////////////////////////////////////////////////////////////////////////////

   assign last_slot = (slot_q == slot_t'(seq_len - 1));

   // Next command goes out as the current frame shifts its last bit
   assign next_load = (state_q != st_idle) && frame_done && !last_slot;

   // Orbit sequence follows straight on when a tick is waiting
   assign chain_orbit = (state_q != st_idle) && frame_done && last_slot &&
                        (pending_q || orbit_tick);

   assign cmd_load = load_q || next_load || chain_orbit;
   assign busy     = (state_q != st_idle);

   ////////////////////////////////////////////////////////////////////////////
   // Command lookup
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      use_orbit = (state_q == st_orbit) || chain_orbit;
      if (load_q) begin
         cmd_slot = slot_q;
      end else if (last_slot) begin
         cmd_slot = '0;
      end else begin
         cmd_slot = slot_t'(slot_q + 1'b1);
      end

      if (use_orbit) begin
         case (cmd_slot)
            2'd0:    cmd = cmd_start;
            2'd1:    cmd = cmd_start;
            2'd2:    cmd = cmd_bc0;
            default: cmd = cmd_stop;
         endcase
      end else begin
         case (cmd_slot)
            2'd0:    cmd = cmd_start;
            2'd1:    cmd = cmd_dtu_reset;
            2'd2:    cmd = cmd_normal_mode;
            default: cmd = cmd_stop;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // State machine
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!RST_A) begin
         state_q   <= st_idle;
         slot_q    <= '0;
         pending_q <= 1'b0;
         load_q    <= 1'b0;
      end else begin
         load_q <= 1'b0;
         case (state_q)
            st_idle: begin
               // Orbit has priority over a simultaneous start-up request
               if (orbit_tick) begin
                  state_q <= st_orbit;
                  slot_q  <= '0;
                  load_q  <= 1'b1;
               end else if (init_req) begin
                  state_q <= st_startup;
                  slot_q  <= '0;
                  load_q  <= 1'b1;
               end
            end
            default: begin
               if (orbit_tick) begin
                  pending_q <= 1'b1;
               end
               if (next_load) begin
                  slot_q <= slot_t'(slot_q + 1'b1);
               end else if (chain_orbit) begin
                  state_q   <= st_orbit;
                  slot_q    <= '0;
                  pending_q <= 1'b0;
               end else if (frame_done) begin
                  state_q <= st_idle;
               end
            end
         endcase
      end
   end

endmodule

/* rtl/sync_timing_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Timing definitions for the resync transmitter
// Counter widths for the orbit timer, frame bit index and sequence slots
////////////////////////////////////////////////////////////////////////////

package sync_timing_pkg;

   // Orbit counter, wide enough for a full LHC orbit of 3564 cycles
   localparam int orbit_cnt_bits = 16;
   typedef logic [orbit_cnt_bits-1:0] orbit_cnt_t;

   // Bit position inside an 8-bit frame
   localparam int bit_cnt_bits = 3;
   typedef logic [bit_cnt_bits-1:0] bit_cnt_t;

   // Commands in each sequence
   localparam int seq_len = 4;

   // Slot of a command inside a sequence
   localparam int slot_bits = $clog2(seq_len);
   typedef logic [slot_bits-1:0] slot_t;

endpackage

/* rtl/sync_tx_top.sv */
////////////////////////////////////////////////////////////////////////////
// Resync transmitter top level
// Orbit timer, command sequencer and serializer driving the resync line
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module sync_tx_top #(
   parameter int orbit_period = 3564
) (
   input  logic clk,
   input  logic RST_A,
   input  logic init_req,
   input  logic orbit_enable,
   output logic resync,
   output logic frame_strobe,
   output logic busy
);

   import sync_cmd_pkg::*;

   logic orbit_tick;
   cmd_t cmd;
   logic cmd_load;
   logic frame_done;

   // Orbit boundary source
   orbit_timer #(
      .orbit_period (orbit_period)
   ) u_orbit_timer (
      .clk          (clk),
      .RST_A        (RST_A),
      .orbit_enable (orbit_enable),
      .orbit_tick   (orbit_tick)
   );

   // Sequence selection and command issue
   sync_sequencer u_sync_sequencer (
      .clk        (clk),
      .RST_A      (RST_A),
      .init_req   (init_req),
      .orbit_tick (orbit_tick),
      .frame_done (frame_done),
      .cmd        (cmd),
      .cmd_load   (cmd_load),
      .busy       (busy)
   );

   // Encoding and serial output
   command_serializer u_command_serializer (
      .clk          (clk),
      .RST_A        (RST_A),
      .cmd          (cmd),
      .cmd_load     (cmd_load),
      .resync       (resync),
      .frame_strobe (frame_strobe),
      .frame_done   (frame_done)
   );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the resync transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f list.f \
   --top-module tb_sync_tx -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
   exit 0
fi
exit 1

/* verification/tb_sync_checks.svh */
////////////////////////////////////////////////////////////////////////////
// Testbench checks for the resync transmitter
// Reference frame encoding, xorshift generator and typed compare tasks
////////////////////////////////////////////////////////////////////////////

`ifndef TB_SYNC_CHECKS_SVH
`define TB_SYNC_CHECKS_SVH

// Expected frame straight from the (8,4) code table
function automatic frame_t encode_ref(input cmd_t c);
   logic p0;
   logic p1;
   logic p3;
   p0 = ^(c & 4'b1011);
   p1 = ^(c & 4'b1101);
   p3 = ^(c & 4'b1110);
   return {1'b0, c[3:1], p3, c[0], p1, p0};
endfunction

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

task automatic check_frame(input string name, input frame_t got, input frame_t exp);
   if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%02h expected 0x%02h", name, got, exp);
   end
endtask

task automatic check_level(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
   end
endtask

// Cycle numbers and event counts
task automatic check_count(input string name, input int got, input int exp);
   if (got != exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
   end
endtask

`endif

/* verification/tb_sync_tx.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the resync transmitter
// Start-up and orbit sequences, chained requests and ignored requests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_sync_tx;

   import sync_cmd_pkg::*;

   localparam int orbit_period   = 200;
   localparam int timeout_cycles = 4 * orbit_period + 400;

   logic   clk;
   logic   RST_A;
   logic   init_req;
   logic   orbit_enable;
   logic   resync;
   logic   frame_strobe;
   logic   busy;

   int     errors;
   int     cycle;
   int     frames_seen;
   int     cap_cnt;
   frame_t cap_shift;
   logic   busy_prev;
   // Event logs in negedge cycle numbers
   int     strobe_q[$];
   int     rise_q[$];
   int     fall_q[$];
   frame_t frame_q[$];
   cmd_t   exp_q[$];

   `include "tb_sync_checks.svh"

   sync_tx_top #(
      .orbit_period (orbit_period)
   ) dut (
      .clk          (clk),
      .RST_A        (RST_A),
      .init_req     (init_req),
      .orbit_enable (orbit_enable),
      .resync       (resync),
      .frame_strobe (frame_strobe),
      .busy         (busy)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   initial begin : watchdog
      while (cycle < timeout_cycles) @(posedge clk);
      $display("Timeout after %0d cycles with %0d errors", timeout_cycles, errors);
      $display("Result: FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Frame capture and compare
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (RST_A) begin
         if (frame_strobe) begin
            if (cap_cnt != 0) begin
               errors++;
               $display("Frame strobe came after only %0d bits of a frame", cap_cnt);
            end
            strobe_q.push_back(cycle);
            cap_shift = {{(frame_bits-1){1'b0}}, resync};
            cap_cnt   = 1;
         end else if (cap_cnt != 0) begin
            cap_shift = {cap_shift[frame_bits-2:0], resync};
            cap_cnt++;
         end
         if (cap_cnt == frame_bits) begin
            frame_q.push_back(cap_shift);
            cap_cnt = 0;
         end
         if (busy && !busy_prev) rise_q.push_back(cycle);
         if (!busy && busy_prev) fall_q.push_back(cycle);
         busy_prev = busy;
      end
   end

   always @(negedge clk) begin : compare
      frame_t got;
      while (frame_q.size() > 0) begin
         got = frame_q.pop_front();
         frames_seen++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("Unexpected frame 0x%02h on resync", got);
         end else begin
            check_frame("resync frame", got, encode_ref(exp_q.pop_front()));
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic expect_seq(input logic orbit);
      exp_q.push_back(cmd_start);
      exp_q.push_back(orbit ? cmd_start : cmd_dtu_reset);
      exp_q.push_back(orbit ? cmd_bc0 : cmd_normal_mode);
      exp_q.push_back(cmd_stop);
   endtask

   // init_req visible from cycle c for one cycle
   task automatic pulse_init_at(input int c);
      @(negedge clk);
      while (cycle < c - 1) @(negedge clk);
      @(posedge clk);
      init_req <= 1'b1;
      @(posedge clk);
      init_req <= 1'b0;
   endtask

   // Strobes 8 cycles apart, starting at first_cycle
   task automatic check_strobes(input int first, input int n, input int first_cycle);
      while (strobe_q.size() < first + n) @(negedge clk);
      for (int k = 0; k < n; k++) begin
         check_count("frame_strobe cycle", strobe_q[first + k], first_cycle + 8 * k);
      end
   endtask

   initial begin : stimulus
      int          c;
      int          e;
      logic [31:0] rng;
      rng = 32'd25;
      RST_A        <= 1'b0;
      init_req     <= 1'b0;
      orbit_enable <= 1'b0;
      repeat (10) @(posedge clk);
      RST_A <= 1'b1;

      // Quiet line after reset
      repeat (20) begin
         @(negedge clk);
         check_level("resync", resync, 1'b0);
         check_level("frame_strobe", frame_strobe, 1'b0);
         check_level("busy", busy, 1'b0);
      end

      // Start-up sequence, a second request while busy is dropped
      c = cycle + 2;
      expect_seq(1'b0);
      pulse_init_at(c);
      pulse_init_at(c + 12);
      check_strobes(0, 4, c + 2);
      while (fall_q.size() < 1) @(negedge clk);
      check_count("busy rise cycle", rise_q[0], c + 1);
      check_count("busy fall cycle", fall_q[0], c + 34);

      // Orbit sequences one period apart
      @(posedge clk);
      orbit_enable <= 1'b1;
      @(negedge clk);
      e = cycle;
      expect_seq(1'b1);
      check_strobes(4, 4, e + orbit_period + 2);
      expect_seq(1'b1);
      check_strobes(8, 4, e + 2 * orbit_period + 2);

      // Start-up just before the third tick, orbit chained right behind
      rng = xorshift32(rng);
      c   = e + 3 * orbit_period - (2 + int'(rng % 32'd24));
      expect_seq(1'b0);
      expect_seq(1'b1);
      pulse_init_at(c);
      check_strobes(12, 4, c + 2);
      check_strobes(16, 4, c + 34);
      while (fall_q.size() < 4) @(negedge clk);
      check_count("busy fall cycle", fall_q[3], c + 66);

      // Request in the middle of the fourth orbit sequence
      expect_seq(1'b1);
      pulse_init_at(e + 4 * orbit_period + 10);
      check_strobes(20, 4, e + 4 * orbit_period + 2);
      while (fall_q.size() < 5) @(negedge clk);
      @(posedge clk);
      orbit_enable <= 1'b0;
      repeat (40) @(negedge clk);
      check_count("sequence count", rise_q.size(), 5);
      check_count("frame count", frames_seen, 24);
      check_count("frames still expected", exp_q.size(), 0);

      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
